// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module tb_apple_video \
		--Mdir obj_dir -o sim_apple_video
	./obj_dir/sim_apple_video | tee run.log
	@if grep -q '\*\* FAIL \*\*' run.log; then echo "Simulation failed, see run.log"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' run.log; then echo "No result in run.log"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f project.f --top-module tb_apple_video

clean:
	rm -rf obj_dir run.log

// ==== logic/apple_video.sv ====
module apple_video (
    input  logic                  a2bus_if,
    input  logic                  arst_n_i,
    input  video_pkg::coord_t     screen_x_i,
    input  video_pkg::coord_t     screen_y_i,
    input  video_pkg::mode_ctrl_t mode_i,
    output video_pkg::fetch_req_t mem_req_o,
    output logic                  mem_req_valid_o,
    input  logic                  mem_credit_i,
    input  video_pkg::vdata_t     mem_rdata_i,
    input  logic                  mem_rvalid_i,
    output logic                  video_active_o,
    output video_pkg::color_idx_t pix_color_o,
    output video_pkg::rgb_t       video_rgb_o,
    output logic                  underrun_o
);
    import video_pkg::*;

    scan_ctrl_t scan_w;  // Scan state, one cycle after the beam
    mode_ctrl_t mode_w;  // Mode latched in blanking
    logic       pix_w;   // Serial dot stream

    // ------------------------------
    // Scanner and fetch
    // ------------------------------
    video_decode u_decode (
        .a2bus_if        (a2bus_if),
        .arst_n_i        (arst_n_i),
        .screen_x_i      (screen_x_i),
        .screen_y_i      (screen_y_i),
        .mode_i          (mode_i),
        .mem_credit_i    (mem_credit_i),
        .scan_o          (scan_w),
        .mode_o          (mode_w),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o)
    );

    pixel_expand u_expand (
        .a2bus_if     (a2bus_if),
        .arst_n_i     (arst_n_i),
        .scan_i       (scan_w),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .pix_o        (pix_w),
        .underrun_o   (underrun_o)
    );

    // Color stage
    color_result u_color (
        .a2bus_if       (a2bus_if),
        .arst_n_i       (arst_n_i),
        .scan_i         (scan_w),
        .mode_i         (mode_w),
        .pix_i          (pix_w),
        .video_active_o (video_active_o),
        .pix_color_o    (pix_color_o),
        .video_rgb_o    (video_rgb_o)
    );

endmodule

// ==== logic/color_result.sv ====
module color_result (
    input  logic                  a2bus_if,
    input  logic                  arst_n_i,
    input  video_pkg::scan_ctrl_t scan_i,
    input  video_pkg::mode_ctrl_t mode_i,
    input  logic                  pix_i,
    output logic                  video_active_o,
    output video_pkg::color_idx_t pix_color_o,
    output video_pkg::rgb_t       video_rgb_o
);
    import video_pkg::*;

    logic [PIX_HISTORY_SIZE-1:0] hist_q;
    logic [1:0]                  phase_q;  // Dot position modulo 4
    color_idx_t                  nib_q;
    logic                        nib_cap_w;
    color_idx_t                  hist_nib_w;
    color_idx_t                  nib_w;
    color_idx_t                  art_w;
    color_idx_t                  rot_art_w;
    color_idx_t                  color_w;

    // ------------------------------
    // Pixel history and phase
    // ------------------------------
    always_ff @(posedge a2bus_if) begin
        hist_q <= {pix_i, hist_q[PIX_HISTORY_SIZE-1:1]};
        nib_q  <= nib_w;
    end

    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= '0;
        end else if (!scan_i.scan_active && !scan_i.draw_active) begin
            phase_q <= '0;  // Idle between lines
        end else begin
            phase_q <= phase_q + 2'd1;
        end
    end

    // Lores nibble, taken at the start of each 14-dot block
    assign nib_cap_w = (scan_i.step == 5'(SCAN_PIX_OFFSET - STEP_LENGTH))
                    || (scan_i.step == 5'(SCAN_PIX_OFFSET - STEP_LENGTH / 2));

    always_comb begin
        case (phase_q)
            2'd0:    hist_nib_w = hist_q[7:4];
            2'd1:    hist_nib_w = {hist_q[6:4], hist_q[7]};
            2'd2:    hist_nib_w = {hist_q[5:4], hist_q[7:6]};
            default: hist_nib_w = {hist_q[4], hist_q[7:5]};
        endcase
    end

    assign nib_w = nib_cap_w ? hist_nib_w : nib_q;

    // Hires artifact color, rotated to the dot phase
    assign art_w = artifact_color(hist_q[HISTORY_ARTIFACT_OFFSET +: 7]);

    always_comb begin
        case (phase_q)
            2'd0:    rot_art_w = art_w;
            2'd1:    rot_art_w = {art_w[2:0], art_w[3]};
            2'd2:    rot_art_w = {art_w[1:0], art_w[3:2]};
            default: rot_art_w = {art_w[0], art_w[3:1]};
        endcase
    end

    // ------------------------------
    // Color choice
    // ------------------------------
    always_comb begin
        if (!scan_i.draw_active) begin
            color_w = BORDER_COLOR;
        end else if (mode_i.monochrome) begin
            color_w = hist_q[HISTORY_PIXEL_OFFSET] ? 4'hf : 4'h0;
        end else begin
            case (scan_i.line_mode)
                LINE_HIRES40: color_w = rot_art_w;
                LINE_LORES40: color_w = nib_w;
                default:      color_w = BORDER_COLOR;
            endcase
        end
    end

    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            video_active_o <= 1'b0;
            pix_color_o    <= BORDER_COLOR;
        end else begin
            video_active_o <= scan_i.draw_active;  // Same stage as the color
            pix_color_o    <= color_w;
        end
    end

    assign video_rgb_o = palette_rgb(pix_color_o);

endmodule

// ==== logic/pixel_expand.sv ====
module pixel_expand (
    input  logic                  a2bus_if,
    input  logic                  arst_n_i,
    input  video_pkg::scan_ctrl_t scan_i,
    input  video_pkg::vdata_t     mem_rdata_i,
    input  logic                  mem_rvalid_i,
    output logic                  pix_o,
    output logic                  underrun_o
);
    import video_pkg::*;

    vdata_t   data_q;   // Last returned word
    vdata_t   word_q;   // Word for the current step
    logic     got_q;    // Return seen since step 0
    logic     first_q;  // Next load is the first of the line
    logic     delay_q;
    pix_buf_t buf_q;
    pix_buf_t shift_q;
    logic     carry_w;

    // Hires40, each dot doubled, bit 7 of a byte shifts it by half a dot
    function automatic pix_buf_t expand_hires40(input vdata_t vd);
        logic [13:0] lo;
        logic [13:0] hi;
        pix_buf_t    pb;
        for (int i = 0; i < 7; i++) begin
            lo[2*i +: 2] = {2{vd[i]}};
            hi[2*i +: 2] = {2{vd[16+i]}};
        end
        pb[13:0]  = vd[7] ? {lo[12:0], 1'b0} : lo;  // Bit 0 filled at load
        pb[28:14] = vd[23] ? {hi, lo[13]} : {1'b0, hi};
        return pb;
    endfunction

    // Lores40, one nibble per byte repeated across 14 dots
    function automatic logic [27:0] expand_lores40(input vdata_t vd, input logic seg);
        logic [3:0]  lo_nib;
        logic [3:0]  hi_nib;
        logic [27:0] px;
        lo_nib = seg ? vd[7:4] : vd[3:0];
        hi_nib = seg ? vd[23:20] : vd[19:16];
        for (int i = 0; i < 28; i++) begin
            px[i] = (i < 14) ? lo_nib[i % 4] : hi_nib[i % 4];
        end
        return px;
    endfunction

    // ------------------------------
    // Return tracking and underrun
    // ------------------------------
    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            got_q      <= 1'b0;
            first_q    <= 1'b1;
            underrun_o <= 1'b0;
        end else begin
            underrun_o <= 1'b0;
            if (mem_rvalid_i) begin
                got_q <= 1'b1;
            end else if (scan_i.step == '0) begin
                got_q <= 1'b0;
            end
            if (scan_i.scan_active && scan_i.step == 5'(STEP_LATCH)) begin
                underrun_o <= !(got_q || mem_rvalid_i);  // Late fetch, draw black
            end
            if (!scan_i.scan_active) begin
                first_q <= 1'b1;
            end else if (scan_i.step == 5'(STEP_LENGTH - 1)) begin
                first_q <= 1'b0;
            end
        end
    end

    // No pixel left of the window, so the first delayed dot repeats its neighbour
    assign carry_w = !delay_q ? buf_q[0] : (first_q ? buf_q[1] : shift_q[0]);

    // ------------------------------
    // Expansion and shift register
    // ------------------------------
    always_ff @(posedge a2bus_if) begin
        if (mem_rvalid_i) data_q <= mem_rdata_i;

        if (scan_i.scan_active && scan_i.step == 5'(STEP_LATCH)) begin
            word_q <= mem_rvalid_i ? mem_rdata_i : (got_q ? data_q : '0);
        end

        if (scan_i.scan_active && scan_i.step == 5'(STEP_LATCH + 1)) begin
            case (scan_i.line_mode)
                LINE_HIRES40: begin
                    buf_q   <= expand_hires40(word_q);
                    delay_q <= word_q[7];
                end
                LINE_LORES40: begin
                    buf_q   <= {1'b0, expand_lores40(word_q, scan_i.lores_seg)};
                    delay_q <= 1'b0;
                end
                default: begin
                    buf_q   <= '0;
                    delay_q <= 1'b0;
                end
            endcase
        end

        if (scan_i.scan_active && scan_i.step == 5'(STEP_LENGTH - 1)) begin
            shift_q <= {buf_q[PIX_BUFFER_SIZE-1:1], carry_w};
        end else begin
            shift_q <= {1'b0, shift_q[PIX_BUFFER_SIZE-1:1]};
        end
    end

    assign pix_o = shift_q[0];

    a_one_return_per_step: assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        mem_rvalid_i && scan_i.step != '0 |-> !got_q);

endmodule

// ==== logic/video_decode.sv ====
module video_decode (
    input  logic                  a2bus_if,
    input  logic                  arst_n_i,
    input  video_pkg::coord_t     screen_x_i,
    input  video_pkg::coord_t     screen_y_i,
    input  video_pkg::mode_ctrl_t mode_i,
    input  logic                  mem_credit_i,
    output video_pkg::scan_ctrl_t scan_o,
    output video_pkg::mode_ctrl_t mode_o,
    output video_pkg::fetch_req_t mem_req_o,
    output logic                  mem_req_valid_o
);
    import video_pkg::*;

    logic                                  x_scan_w;
    logic                                  x_draw_w;
    logic                                  y_act_w;
    logic                                  blank_w;
    logic                                  scan_start_w;
    coord_t                                win_y_w;
    logic [7:0]                            row_w;
    scan_ctrl_t                            scan_nxt;
    logic                                  issue_w;
    logic [$clog2(FETCH_CREDITS + 1)-1:0] credit_q;
    logic [$clog2(FETCH_CREDITS + 1)-1:0] credit_nxt;
    logic [5:0]                            h_off_q;  // Grows by 2 bytes per fetch

    // Line base address, Sather layout
    function automatic vaddr_t line_addr(input logic [7:0] row, input mode_ctrl_t m);
        vaddr_t a;
        a      = '0;
        a[6:3] = {1'b1, row[6], 1'b1, 1'b1} + {row[7], 1'b1, row[7], 1'b1}
               + {3'b000, row[6]};
        a[9:7] = row[5:3];
        if (m.hires) begin
            a[14:10] = {m.page2, ~m.page2, row[2:0]};  // 0x2000 or 0x4000
        end else begin
            a[11:10] = {m.page2, ~m.page2};            // 0x400 or 0x800
        end
        return a;
    endfunction

    // ------------------------------
    // Beam window decode
    // ------------------------------
    assign x_scan_w = (screen_x_i >= coord_t'(H_BORDER - SCAN_PIX_OFFSET))
                   && (screen_x_i < coord_t'(H_BORDER - SCAN_PIX_OFFSET + WINDOW_WIDTH));
    assign x_draw_w = (screen_x_i >= coord_t'(H_BORDER))
                   && (screen_x_i < coord_t'(H_BORDER + WINDOW_WIDTH));
    assign y_act_w  = (screen_y_i >= coord_t'(V_BORDER))
                   && (screen_y_i < coord_t'(V_BORDER + WINDOW_HEIGHT));
    assign blank_w  = (screen_x_i > coord_t'(SCREEN_WIDTH))
                   || (screen_y_i > coord_t'(SCREEN_HEIGHT));
    assign scan_start_w = (screen_x_i == coord_t'(H_BORDER - SCAN_PIX_OFFSET)) && y_act_w;

    assign win_y_w = screen_y_i - coord_t'(V_BORDER);
    assign row_w   = win_y_w[8:1];  // Each row is drawn twice

    always_comb begin
        scan_nxt.scan_active = x_scan_w && y_act_w;
        scan_nxt.draw_active = x_draw_w && y_act_w;
        scan_nxt.lores_seg   = row_w[2];
        if (scan_start_w || scan_o.step == 5'(STEP_LENGTH - 1)) begin
            scan_nxt.step = '0;
        end else begin
            scan_nxt.step = scan_o.step + 5'd1;
        end
        if (!y_act_w) begin
            scan_nxt.line_mode = LINE_BLANK;
        end else if (mode_o.hires) begin
            scan_nxt.line_mode = LINE_HIRES40;
        end else begin
            scan_nxt.line_mode = LINE_LORES40;
        end
    end

    // ------------------------------
    // Fetch issue under credits
    // ------------------------------
    assign issue_w = scan_nxt.scan_active && (scan_nxt.step == '0) && (credit_q != '0);

    always_comb begin
        credit_nxt = credit_q;
        if (issue_w) credit_nxt = credit_nxt - 1'b1;
        if (mem_credit_i) credit_nxt = credit_nxt + 1'b1;
    end

    always_ff @(posedge a2bus_if or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scan_o          <= '{scan_active: 1'b0, draw_active: 1'b0, step: '0,
                                 lores_seg: 1'b0, line_mode: LINE_BLANK};
            mode_o          <= '0;
            credit_q        <= ($clog2(FETCH_CREDITS + 1))'(FETCH_CREDITS);
            h_off_q         <= '0;
            mem_req_valid_o <= 1'b0;
        end else begin
            scan_o          <= scan_nxt;
            credit_q        <= credit_nxt;
            mem_req_valid_o <= issue_w;
            if (blank_w) mode_o <= mode_i;  // No mode change mid-frame
            if (!scan_nxt.scan_active) begin
                h_off_q <= '0;
            end else if (scan_nxt.step == '0) begin
                h_off_q <= h_off_q + 6'd2;  // Skipped fetches advance too
            end
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (issue_w) mem_req_o.addr <= line_addr(row_w, mode_o) + {10'd0, h_off_q};
    end

    a_credit_bound: assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        credit_q <= FETCH_CREDITS);

    a_req_has_credit: assert property (@(posedge a2bus_if) disable iff (!arst_n_i)
        mem_req_valid_o |-> $past(credit_q) != '0);

endmodule

// ==== logic/video_pkg.sv ====
package video_pkg;

    // ------------------------------
    // Screen geometry and timing
    // ------------------------------
    localparam int WINDOW_WIDTH            = 560;
    localparam int WINDOW_HEIGHT           = 384;
    localparam int SCREEN_WIDTH            = 720;
    localparam int SCREEN_HEIGHT           = 480;
    localparam int H_BORDER                = 80;
    localparam int V_BORDER                = 48;

    localparam int STEP_LENGTH             = 28;  // Pixels per fetch
    localparam int STEP_LATCH              = 14;  // Fetch data due here
    localparam int PIX_BUFFER_SIZE         = 29;  // 28 pixels plus delay bit
    localparam int PIX_HISTORY_SIZE        = 8;
    localparam int HISTORY_PIXEL_OFFSET    = 4;
    localparam int HISTORY_ARTIFACT_OFFSET = 1;
    localparam int SCAN_PIX_OFFSET         = 32;  // Scan runs ahead of drawing
    localparam int FETCH_CREDITS           = 2;

    // ------------------------------
    // Vector types
    // ------------------------------
    typedef logic [9:0]                 coord_t;
    typedef logic [15:0]                vaddr_t;
    typedef logic [31:0]                vdata_t;
    typedef logic [PIX_BUFFER_SIZE-1:0] pix_buf_t;
    typedef logic [3:0]                 color_idx_t;
    typedef logic [11:0]                rgb_t;

    localparam color_idx_t BORDER_COLOR = 4'd0;

    typedef enum logic [1:0] {
        LINE_HIRES40,
        LINE_LORES40,
        LINE_BLANK
    } line_mode_e;

    typedef struct packed {
        logic hires;
        logic page2;
        logic monochrome;
    } mode_ctrl_t;

    typedef struct packed {
        vaddr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic       scan_active;
        logic       draw_active;
        logic [4:0] step;       // Position inside the 28-cycle fetch
        logic       lores_seg;  // Upper or lower lores block
        line_mode_e line_mode;
    } scan_ctrl_t;

    // Artifact colors, 7-pixel window in, palette index out
    // Entry 0 sits in the top nibble so rows read in index order
    localparam logic [511:0] ARTIFACT_TABLE = {
        64'h0000_8000_1151_99df, 64'h2266_aaee_3333_bbff,
        64'h0044_cccc_5555_99df, 64'h0266_eaee_7777_ffff,
        64'h0000_8888_1151_99df, 64'h0266_aaaa_3333_bbff,
        64'h0044_cccc_1155_99dd, 64'h0266_eaee_fff7_ffff
    };

    function automatic color_idx_t artifact_color(input logic [6:0] win);
        return ARTIFACT_TABLE[511 - 4 * win -: 4];
    endfunction

    // Apple II colors in sRGB, 4 bits per channel
    function automatic rgb_t palette_rgb(input color_idx_t idx);
        case (idx)
            4'd0:    return 12'h000;  // Black
            4'd1:    return 12'h924;  // Magenta
            4'd2:    return 12'h42a;
            4'd3:    return 12'hd4e;  // Purple
            4'd4:    return 12'h064;
            4'd5:    return 12'h888;
            4'd6:    return 12'h39e;  // Blue
            4'd7:    return 12'hcbf;
            4'd8:    return 12'h450;  // Brown
            4'd9:    return 12'hc73;  // Orange
            4'd10:   return 12'h888;
            4'd11:   return 12'hfac;
            4'd12:   return 12'h3c2;  // Green
            4'd13:   return 12'hcd6;
            4'd14:   return 12'h7ec;
            default: return 12'hfff;  // White
        endcase
    endfunction

endpackage

// ==== project.f ====
logic/video_pkg.sv
logic/video_decode.sv
logic/pixel_expand.sv
logic/color_result.sv
logic/apple_video.sv
test/video_checker.sv
test/tb_apple_video.sv

// ==== test/tb_apple_video.sv ====
module tb_apple_video;
    timeunit 1ns;
    timeprecision 1ps;
    import video_pkg::*;

    localparam int LINE_LEN       = 728;  // Past 720 so each line has blanking
    localparam int NUM_LINES      = 7;
    localparam int NUM_TESTS      = 8;
    localparam int FRAME_CYCLES   = LINE_LEN * NUM_LINES;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * FRAME_CYCLES + 1000;

    typedef struct packed {
        mode_ctrl_t mode;
        logic       addr_fill;  // Word built from the address
        vdata_t     fill;
        logic [4:0] latency;
        color_idx_t color;
        logic       check_color;
    } test_row_t;

    // Reduced frame, inactive lines around rows 0, 7, 8, 64 and 191
    localparam coord_t FRAME_LINES [NUM_LINES] = '{
        10'd44, 10'd48, 10'd63, 10'd65, 10'd177, 10'd431, 10'd432
    };

    // Mode {hires, page2, mono}, address fill, word, latency, color, color check
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{3'b100, 1'b0, 32'h0000_0000, 5'd1,  4'd0,  1'b1},
        '{3'b110, 1'b0, 32'hffff_ffff, 5'd14, 4'd15, 1'b1},  // Data right at the latch
        '{3'b000, 1'b0, 32'h5555_5555, 5'd5,  4'd5,  1'b1},
        '{3'b010, 1'b0, 32'haaaa_aaaa, 5'd9,  4'd10, 1'b1},
        '{3'b000, 1'b0, 32'hcccc_cccc, 5'd2,  4'd12, 1'b1},
        '{3'b101, 1'b0, 32'hffff_ffff, 5'd7,  4'd15, 1'b1},
        '{3'b110, 1'b1, 32'h0000_0000, 5'd11, 4'd0,  1'b0},
        '{3'b100, 1'b0, 32'hffff_ffff, 5'd20, 4'd0,  1'b1}   // Late, drawn black
    };

    logic       a2bus_if;
    logic       arst_n;
    coord_t     screen_x;
    coord_t     screen_y;
    mode_ctrl_t mode;
    fetch_req_t mem_req;
    logic       mem_req_valid;
    logic       mem_credit;
    vdata_t     mem_rdata;
    logic       mem_rvalid;
    logic       video_active;
    color_idx_t pix_color;
    rgb_t       video_rgb;
    logic       underrun;

    test_row_t  cur_test;
    logic       exp_underrun;
    int         cycle_cnt = 0;
    int         due_q[$];   // Cycle at which each read returns
    vaddr_t     addr_q[$];
    int         error_count;
    int         pixel_count;
    int         req_count;

    assign exp_underrun = int'(cur_test.latency) > STEP_LATCH;

    apple_video DUT (
        .a2bus_if        (a2bus_if),
        .arst_n_i        (arst_n),
        .screen_x_i      (screen_x),
        .screen_y_i      (screen_y),
        .mode_i          (mode),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_credit_i    (mem_credit),
        .mem_rdata_i     (mem_rdata),
        .mem_rvalid_i    (mem_rvalid),
        .video_active_o  (video_active),
        .pix_color_o     (pix_color),
        .video_rgb_o     (video_rgb),
        .underrun_o      (underrun)
    );

    video_checker #(.LINE_LEN(LINE_LEN)) u_checker (
        .a2bus_if        (a2bus_if),
        .arst_n_i        (arst_n),
        .screen_x_i      (screen_x),
        .screen_y_i      (screen_y),
        .mode_i          (mode),
        .exp_color_i     (cur_test.color),
        .check_color_i   (cur_test.check_color),
        .exp_underrun_i  (exp_underrun),
        .mem_req_i       (mem_req),
        .mem_req_valid_i (mem_req_valid),
        .mem_credit_i    (mem_credit),
        .video_active_i  (video_active),
        .pix_color_i     (pix_color),
        .video_rgb_i     (video_rgb),
        .underrun_i      (underrun),
        .error_count_o   (error_count),
        .pixel_count_o   (pixel_count),
        .req_count_o     (req_count)
    );

    initial begin
        a2bus_if = 1'b0;
        forever #2 a2bus_if = ~a2bus_if;
    end

    always @(posedge a2bus_if) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------
    // Memory model
    // ------------------------------
    function automatic vdata_t word_for_addr(input vaddr_t addr);
        if (cur_test.addr_fill) return {addr ^ 16'h5aa5, addr};
        return cur_test.fill;
    endfunction

    always @(posedge a2bus_if) begin
        #1;
        mem_rvalid = 1'b0;
        mem_credit = 1'b0;
        if (arst_n && mem_req_valid) begin
            due_q.push_back(cycle_cnt + int'(cur_test.latency));
            addr_q.push_back(mem_req.addr);
        end
        if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
            mem_rdata  = word_for_addr(addr_q.pop_front());
            mem_rvalid = 1'b1;
            mem_credit = 1'b1;  // Credit goes back with its word
            void'(due_q.pop_front());
        end
    end

    task automatic sweep_frame();
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int x = 0; x < LINE_LEN; x++) begin
                @(posedge a2bus_if);
                #1;
                screen_x = coord_t'(x);
                screen_y = FRAME_LINES[l];
            end
        end
    endtask

    // ------------------------------
    // Stimulus table, one frame per row
    // ------------------------------
    initial begin
        arst_n     = 1'b0;
        screen_x   = '0;
        screen_y   = '0;
        mode       = '0;
        mem_credit = 1'b0;
        mem_rdata  = '0;
        mem_rvalid = 1'b0;
        cur_test   = TESTS[0];
        repeat (2) @(posedge a2bus_if);
        #1 arst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = TESTS[t];
            mode     = cur_test.mode;  // Taken by the DUT in the next blanking
            sweep_frame();
        end
        repeat (4) @(posedge a2bus_if);
        #1;
        $display("Checks done: %0d active pixels, %0d requests, %0d errors",
                 pixel_count, req_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== test/video_checker.sv ====
module video_checker #(
    parameter int LINE_LEN = 728
) (
    input  logic                  a2bus_if,
    input  logic                  arst_n_i,
    input  video_pkg::coord_t     screen_x_i,
    input  video_pkg::coord_t     screen_y_i,
    input  video_pkg::mode_ctrl_t mode_i,
    input  video_pkg::color_idx_t exp_color_i,
    input  logic                  check_color_i,
    input  logic                  exp_underrun_i,
    input  video_pkg::fetch_req_t mem_req_i,
    input  logic                  mem_req_valid_i,
    input  logic                  mem_credit_i,
    input  logic                  video_active_i,
    input  video_pkg::color_idx_t pix_color_i,
    input  video_pkg::rgb_t       video_rgb_i,
    input  logic                  underrun_i,
    output int                    error_count_o,
    output int                    pixel_count_o,
    output int                    req_count_o
);
    import video_pkg::*;

    localparam int FETCHES_PER_LINE = WINDOW_WIDTH / STEP_LENGTH;

    // Apple II colors, 4 bits per channel
    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e, 12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac, 12'h3c2, 12'hcd6, 12'h7ec, 12'hfff
    };

    int line_reqs;
    int line_pixels;
    int line_underruns;
    int outstanding;  // Requests without a returned credit

    // Standard Apple II line layout, 40 bytes per line in groups of 8 lines
    function automatic vaddr_t expected_addr(input coord_t y, input mode_ctrl_t m,
                                             input int fetch);
        int row;
        int base;
        row  = (int'(y) - V_BORDER) / 2;
        base = ((row / 8) % 8) * 'h80 + (row / 64) * 'h28;
        if (m.hires) begin
            base = base + (m.page2 ? 'h4000 : 'h2000) + (row % 8) * 'h400;
        end else begin
            base = base + (m.page2 ? 'h800 : 'h400);
        end
        return vaddr_t'(base + 2 * fetch);
    endfunction

    task automatic report_error(input string msg);
        error_count_o++;
        $display("[ERROR] %0d ns: %s", $time, msg);
    endtask

    task automatic check_line_totals();
        logic in_window;
        int   exp_reqs;
        int   exp_underruns;
        in_window = (screen_y_i >= coord_t'(V_BORDER))
                 && (screen_y_i < coord_t'(V_BORDER + WINDOW_HEIGHT));
        exp_reqs      = in_window ? FETCHES_PER_LINE : 0;
        exp_underruns = (in_window && exp_underrun_i) ? FETCHES_PER_LINE : 0;
        if (line_reqs != exp_reqs)
            report_error($sformatf("line %0d has %0d requests, expected %0d",
                                   screen_y_i, line_reqs, exp_reqs));
        if (line_pixels != (in_window ? WINDOW_WIDTH : 0))
            report_error($sformatf("line %0d has %0d active pixels", screen_y_i, line_pixels));
        if (line_underruns != exp_underruns)
            report_error($sformatf("line %0d has %0d underruns, expected %0d",
                                   screen_y_i, line_underruns, exp_underruns));
        line_reqs      = 0;
        line_pixels    = 0;
        line_underruns = 0;
    endtask

    initial begin
        error_count_o  = 0;
        pixel_count_o  = 0;
        req_count_o    = 0;
        line_reqs      = 0;
        line_pixels    = 0;
        line_underruns = 0;
        outstanding    = 0;
    end

    // ------------------------------
    // Sampled mid-cycle, away from the edge
    // ------------------------------
    always @(negedge a2bus_if) begin
        if (arst_n_i) begin
            if (video_active_i) begin
                pixel_count_o++;
                line_pixels++;
                if (check_color_i && pix_color_i != exp_color_i)
                    report_error($sformatf("pixel color %0d, expected %0d",
                                           pix_color_i, exp_color_i));
            end else if (pix_color_i != BORDER_COLOR) begin
                report_error($sformatf("border color %0d outside the window", pix_color_i));
            end
            if (video_rgb_i != PALETTE[pix_color_i])
                report_error($sformatf("rgb %h for color %0d, expected %h",
                                       video_rgb_i, pix_color_i, PALETTE[pix_color_i]));

            if (mem_req_valid_i) begin
                if (mem_req_i.addr != expected_addr(screen_y_i, mode_i, line_reqs))
                    report_error($sformatf("request address %h, expected %h", mem_req_i.addr,
                                           expected_addr(screen_y_i, mode_i, line_reqs)));
                line_reqs++;
                req_count_o++;
            end
            outstanding += int'(mem_req_valid_i) - int'(mem_credit_i);
            if (outstanding > FETCH_CREDITS || outstanding < 0)
                report_error($sformatf("%0d requests outstanding", outstanding));
            if (underrun_i) line_underruns++;

            if (screen_x_i == coord_t'(LINE_LEN - 1)) check_line_totals();  // Line is done
        end
    end

endmodule
